//--- Makefile
# Verilator build for the ECC UART link testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_ecc_uart_link
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+design
+incdir+testbench
design/link_pkg.sv
design/uart_rx.sv
design/secded_decoder.sv
design/codeword_tx.sv
design/ecc_uart_link.sv
testbench/tb_ecc_uart_link.sv

//--- design/codeword_tx.sv
// SECDED encoder and UART frame serializer
// Frame is start, codeword LSB first, parity, stop, one bit per 2 half-bit periods
// A send strobe while busy is dropped, there is no queue
// busy stays high for 11 full bits after the accepting edge
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module codeword_tx (
    input  wire       clk,
    input  wire       reset,
    input  wire       send,
    input  wire [3:0] send_nibble,
    output wire       tx,
    output wire       busy
);
    import link_pkg::*;

    localparam int   FULL_BIT   = 2 * `LINK_HALF_BIT_CLKS;
    localparam int   CNT_W      = $clog2(FULL_BIT);
    localparam logic PARITY_ODD = `LINK_PARITY_ODD;

    tx_state_e        state;
    logic [CNT_W-1:0] clk_counter;
    logic [3:0]       bit_index;            // 0 start .. 10 stop
    logic [10:0]      shift_reg;            // Bit 0 drives the line
    logic [7:1]       hamming;              // Hamming positions 1..7
    logic [7:0]       codeword;
    logic             frame_parity;

    // Data bits at positions 3, 5, 6, 7 and parity at 1, 2, 4
    assign hamming[3] = send_nibble[0];
    assign hamming[5] = send_nibble[1];
    assign hamming[6] = send_nibble[2];
    assign hamming[7] = send_nibble[3];
    assign hamming[1] = send_nibble[0] ^ send_nibble[1] ^ send_nibble[3];
    assign hamming[2] = send_nibble[0] ^ send_nibble[2] ^ send_nibble[3];
    assign hamming[4] = send_nibble[1] ^ send_nibble[2] ^ send_nibble[3];

    assign codeword     = {hamming, ^hamming};  // Overall parity in bit 0
    assign frame_parity = (^codeword) ^ PARITY_ODD;

    assign tx   = shift_reg[0];
    assign busy = (state == TX_SHIFT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= TX_IDLE;
            shift_reg   <= '1;              // Line idles high
            clk_counter <= '0;
            bit_index   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (send) begin
                        shift_reg   <= {1'b1, frame_parity, codeword, 1'b0};
                        clk_counter <= '0;
                        bit_index   <= '0;
                        state       <= TX_SHIFT;
                    end
                end

                TX_SHIFT: begin
                    if (clk_counter == CNT_W'(FULL_BIT - 1)) begin
                        clk_counter <= '0;
                        shift_reg   <= {1'b1, shift_reg[10:1]};  // Refill with idle level
                        if (bit_index == 4'd10) begin
                            state <= TX_IDLE;   // Stop bit done
                        end else begin
                            bit_index <= bit_index + 1'b1;
                        end
                    end else begin
                        clk_counter <= clk_counter + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/ecc_uart_link.sv
// One endpoint of the ECC protected UART link
// Receive chain is uart_rx then secded_decoder, transmit is codeword_tx
// Strobes have no back-pressure, a missed rx_valid is lost
// Bit rate and parity sense come from the link macros
`timescale 1ns/1ps
`default_nettype none

module ecc_uart_link (
    input  wire                         clk,
    input  wire                         reset,
    // Host transmit side
    input  wire                         send,
    input  wire [3:0]                   send_nibble,
    output wire                         busy,
    // Serial line
    output wire                         tx,
    input  wire                         rx,
    // Host receive side
    output wire                         rx_valid,
    output wire link_pkg::link_result_t rx_result
);
    import link_pkg::*;

    wire            frame_valid;
    wire rx_frame_t frame;                  // Raw codeword and parity flag

    uart_rx u_uart_rx (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    secded_decoder u_secded_decoder (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .rx_valid    (rx_valid),
        .rx_result   (rx_result)
    );

    codeword_tx u_codeword_tx (
        .clk         (clk),
        .reset       (reset),
        .send        (send),
        .send_nibble (send_nibble),
        .tx          (tx),
        .busy        (busy)
    );

endmodule

`default_nettype wire

//--- design/link_macros.svh
// Bit timing and parity sense shared by the receiver and the transmitter
// Both ends of the link must be built with the same values
// One bit lasts 2 * LINK_HALF_BIT_CLKS clock cycles
`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// Clock cycles in half a bit period
`define LINK_HALF_BIT_CLKS 4

// Frame parity sense, 0 even and 1 odd
`define LINK_PARITY_ODD 0

`endif

//--- design/link_pkg.sv
// Types for the ECC UART link endpoint
// Codeword layout is bit 0 overall parity, bits 1..7 Hamming positions 1..7
// Data bits d0..d3 sit at positions 3, 5, 6 and 7
`default_nettype none

package link_pkg;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_INIT,                            // Wait for an idle line
        RX_IDLE,                            // Look for a start bit
        RX_START,                           // Move to the middle of the start bit
        RX_BITS                             // Sample data, parity and stop slot
    } rx_state_e;

    // Transmitter FSM
    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_e;

    // Received frame, valid while frame_valid is high
    typedef struct packed {
        logic [7:0] codeword;               // SECDED codeword as received
        logic       parity_error;           // Frame parity mismatch
    } rx_frame_t;

    // Decoded result handed to the host
    typedef struct packed {
        logic [3:0] nibble;
        logic       corrected;              // Single error fixed
        logic       uncorrectable;          // Double error seen
        logic       parity_error;           // Frame parity mismatch
    } link_result_t;

endpackage

`default_nettype wire

//--- design/secded_decoder.sv
// SECDED decoder for the 8-bit extended Hamming codeword
// One cycle of latency from frame_valid to rx_valid
// An uncorrectable word passes its data bits through unchanged
// Three or more bit errors can be misreported as a single error
`timescale 1ns/1ps
`default_nettype none

module secded_decoder (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    frame_valid,
    input  wire link_pkg::rx_frame_t frame,
    output logic                   rx_valid,
    output link_pkg::link_result_t rx_result
);
    import link_pkg::*;

    logic [7:0]   cw;
    logic [2:0]   syndrome;
    logic         overall_bad;
    logic [7:0]   fixed_cw;
    logic [7:0]   data_src;
    link_result_t result_next;

    assign cw = frame.codeword;

    // Each syndrome bit covers the positions with that index bit set
    assign syndrome[0] = cw[1] ^ cw[3] ^ cw[5] ^ cw[7];
    assign syndrome[1] = cw[2] ^ cw[3] ^ cw[6] ^ cw[7];
    assign syndrome[2] = cw[4] ^ cw[5] ^ cw[6] ^ cw[7];

    assign overall_bad = ^cw;               // Odd weight means one bit flipped
    assign fixed_cw    = cw ^ (8'b1 << syndrome);   // Zero syndrome hits bit 0
    assign data_src    = overall_bad ? fixed_cw : cw;

    always_comb begin
        result_next.nibble        = {data_src[7], data_src[6], data_src[5], data_src[3]};
        result_next.corrected     = overall_bad;
        result_next.uncorrectable = !overall_bad && (syndrome != 3'b000);
        result_next.parity_error  = frame.parity_error;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= frame_valid;
        end
    end

    // Result payload, loaded with each new frame
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            rx_result <= result_next;
        end
    end

endmodule

`default_nettype wire

//--- design/uart_rx.sv
// UART receiver for the 11-bit frame: start, 8 data LSB first, parity, stop
// The rx line is expected to be synchronous to clk already
// The stop bit slot is waited out but its level is not checked
// frame follows the shift register, so read it in the frame_valid cycle
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module uart_rx (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rx,
    output logic                frame_valid,
    output link_pkg::rx_frame_t frame
);
    import link_pkg::*;

    localparam int   HALF_BIT   = `LINK_HALF_BIT_CLKS;
    localparam int   FULL_BIT   = 2 * HALF_BIT;
    localparam int   CNT_W      = $clog2(FULL_BIT);
    localparam logic PARITY_ODD = `LINK_PARITY_ODD;

    rx_state_e        state;
    logic [CNT_W-1:0] clk_counter;
    logic [3:0]       bit_index;            // 0..8 data and parity, 9 stop slot
    logic [8:0]       shift_reg;            // Parity on top, codeword below

    assign frame.codeword     = shift_reg[7:0];
    assign frame.parity_error = (^shift_reg) != PARITY_ODD;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RX_INIT;
            frame_valid <= 1'b0;
            clk_counter <= '0;
            bit_index   <= '0;
        end else begin
            frame_valid <= 1'b0;            // One-cycle strobe
            case (state)
                RX_INIT: begin
                    if (rx) begin
                        state <= RX_IDLE;   // Idle line seen before the first start
                    end
                end

                RX_IDLE: begin
                    if (!rx) begin
                        clk_counter <= CNT_W'(1);   // Detection cycle already spent
                        bit_index   <= '0;
                        state       <= RX_START;
                    end
                end

                RX_START: begin
                    if (clk_counter == CNT_W'(HALF_BIT - 1)) begin
                        clk_counter <= '0;
                        state       <= RX_BITS;
                    end else begin
                        clk_counter <= clk_counter + 1'b1;
                    end
                end

                RX_BITS: begin
                    if (clk_counter == CNT_W'(FULL_BIT - 1)) begin
                        clk_counter <= '0;
                        bit_index   <= bit_index + 1'b1;
                        if (bit_index == 4'd9) begin
                            frame_valid <= 1'b1;    // Stop slot reached
                            state       <= RX_IDLE;
                        end else begin
                            shift_reg <= {rx, shift_reg[8:1]};  // LSB first
                        end
                    end else begin
                        clk_counter <= clk_counter + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_line_tasks.svh
// Line driver, host strobe, result wait and reference encoder for the link testbench
// Included inside the testbench module body, uses its signals and constants
// Tasks expect to start a few ns after a rising clock edge and end the same way
`ifndef TB_LINE_TASKS_SVH
`define TB_LINE_TASKS_SVH

// Reference SECDED encoder built from the positional Hamming rule
function automatic logic [7:0] encode_nibble(input logic [3:0] nibble);
    logic [7:0] cw;
    int         p;
    int         i;
    cw    = 8'h00;
    cw[3] = nibble[0];
    cw[5] = nibble[1];
    cw[6] = nibble[2];
    cw[7] = nibble[3];
    for (p = 1; p <= 4; p = p * 2) begin
        for (i = 1; i <= 7; i++) begin
            if ((i & p) != 0 && i != p) begin
                cw[p] = cw[p] ^ cw[i];      // Even over covered positions
            end
        end
    end
    cw[0] = ^cw[7:1];
    return cw;
endfunction

// Frame parity bit that gives the selected sense over codeword plus parity
function automatic logic frame_parity(input logic [7:0] cw);
    return (^cw) ^ 1'(`LINK_PARITY_ODD);
endfunction

// Send start, codeword LSB first, parity and stop on the line
task automatic drive_line_frame(input logic [7:0] codeword, input logic parity_bit);
    logic [10:0] bits;
    int          b;
    bits = {1'b1, parity_bit, codeword, 1'b0};
    for (b = 0; b < 11; b++) begin
        line_drv = bits[b];
        repeat (FULL_BIT) @(posedge clk);
        #DRIVE_DELAY;
    end
endtask

// One-cycle send strobe from the host
task automatic host_send(input logic [3:0] nibble);
    send        = 1'b1;
    send_nibble = nibble;
    @(posedge clk);
    #DRIVE_DELAY;
    send = 1'b0;
endtask

task automatic wait_tx_idle();
    int n;
    for (n = 0; n < WAIT_LIMIT; n++) begin
        if (!busy) begin
            return;
        end
        @(posedge clk);
        #DRIVE_DELAY;
    end
    stop_on_error("Timeout: the transmitter stayed busy");
endtask

// Take the oldest result captured by the monitor
task automatic wait_result(output link_result_t res);
    int n;
    for (n = 0; n < WAIT_LIMIT; n++) begin
        if (results.size() > 0) begin
            res = results.pop_front();
            return;
        end
        @(posedge clk);
        #DRIVE_DELAY;
    end
    stop_on_error("Timeout: no rx_valid came from the receive path");
endtask

`endif

//--- testbench/tb_ecc_uart_link.sv
// Testbench for the ECC UART link endpoint
// rx is driven either by the DUT's own tx or by the line driver task
// Checks reset, loopback, single and double errors, parity error and send while busy
// Bit timing and parity sense follow the link macros
`timescale 1ns/1ps
`default_nettype none

`include "link_macros.svh"

module tb_ecc_uart_link;
    import link_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 5;            // ns after the rising edge
    localparam int FULL_BIT     = 2 * `LINK_HALF_BIT_CLKS;
    localparam int FRAME_CLKS   = 11 * FULL_BIT;
    localparam int BUSY_CLKS    = 22 * `LINK_HALF_BIT_CLKS;
    localparam int WAIT_LIMIT   = 3 * FRAME_CLKS;
    localparam int SIM_LIMIT_NS = 1_000_000;

    logic              clk;
    logic              reset;
    logic              send;
    logic [3:0]        send_nibble;
    wire               busy;
    wire               tx;
    wire               rx;
    wire               rx_valid;
    wire link_result_t rx_result;

    logic              use_loopback;           // 1 ties rx to tx
    logic              line_drv;
    integer            seed;
    int                busy_count;
    link_result_t      results[$];             // Results seen on rx_valid

    assign rx = use_loopback ? tx : line_drv;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ecc_uart_link u_ecc_uart_link (
        .clk         (clk),
        .reset       (reset),
        .send        (send),
        .send_nibble (send_nibble),
        .busy        (busy),
        .tx          (tx),
        .rx          (rx),
        .rx_valid    (rx_valid),
        .rx_result   (rx_result)
    );

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    `include "tb_line_tasks.svh"

    idle_line_high: assert property (@(posedge clk) disable iff (reset) !busy |-> tx)
        else stop_on_error($sformatf("FAIL at time %0t: tx low while idle", $time));

    valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else stop_on_error($sformatf("FAIL at time %0t: rx_valid longer than 1 cycle", $time));

    decode_latency: assert property (@(posedge clk) disable iff (reset)
        u_ecc_uart_link.frame_valid |=> rx_valid)
        else stop_on_error($sformatf("FAIL at time %0t: rx_valid not 1 cycle later", $time));

    always @(negedge clk) begin
        if (!reset && rx_valid) begin
            results.push_back(rx_result);
        end
    end

    // Length of each busy period in cycles
    always @(negedge clk) begin
        if (reset) begin
            busy_count = 0;
        end else if (busy) begin
            busy_count++;
        end else if (busy_count != 0) begin
            assert (busy_count == BUSY_CLKS)
                else stop_on_error($sformatf("FAIL at time %0t: busy lasted %0d cycles, not %0d",
                                             $time, busy_count, BUSY_CLKS));
            busy_count = 0;
        end
    end

    task automatic check_reset_state();
        int i;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            assert (tx === 1'b1 && busy === 1'b0 && rx_valid === 1'b0)
                else stop_on_error($sformatf("FAIL at time %0t: tx %b busy %b rx_valid %b",
                                             $time, tx, busy, rx_valid));
        end
    endtask

    task automatic check_result(input link_result_t res, input logic [3:0] nibble,
                                input logic corrected, input logic uncorrectable,
                                input logic parity_error, input logic check_nibble);
        assert ((!check_nibble || res.nibble === nibble) && res.corrected === corrected
                && res.uncorrectable === uncorrectable && res.parity_error === parity_error)
            else stop_on_error($sformatf(
                "FAIL at time %0t: got %h c%b u%b p%b, expected %h c%b u%b p%b", $time,
                res.nibble, res.corrected, res.uncorrectable, res.parity_error,
                nibble, corrected, uncorrectable, parity_error));
        assert (results.size() == 0)
            else stop_on_error($sformatf("FAIL at time %0t: extra rx_valid seen", $time));
    endtask

    initial begin
        #(SIM_LIMIT_NS);
        stop_on_error("Timeout: the simulation ran past its time limit");
    end

    initial begin
        logic [7:0]   pair_masks [0:5];
        link_result_t res;
        logic [3:0]   nib;
        logic [7:0]   cw;
        int           i;
        int           j;

        pair_masks   = '{8'b0000_0011, 8'b0000_0110, 8'b0010_1000,
                         8'b1001_0000, 8'b0100_0100, 8'b1000_0001};
        seed         = 32'hf89a_90d7;
        reset        = 1'b1;
        send         = 1'b0;
        send_nibble  = 4'h0;
        use_loopback = 1'b0;
        line_drv     = 1'b1;                    // Idle line
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        check_reset_state();
        @(posedge clk);
        #DRIVE_DELAY;

        // Loopback over every nibble, then random ones
        use_loopback = 1'b1;
        for (i = 0; i < 24; i++) begin
            if (i < 16) begin
                nib = 4'(i);
            end else begin
                nib = 4'($random(seed));
            end
            wait_tx_idle();
            host_send(nib);
            assert (busy === 1'b1 && tx === 1'b0)
                else stop_on_error($sformatf("FAIL at time %0t: no start bit after send",
                                             $time));
            wait_result(res);
            check_result(res, nib, 1'b0, 1'b0, 1'b0, 1'b1);
        end
        wait_tx_idle();
        use_loopback = 1'b0;

        // One flipped bit at each position
        nib = 4'($random(seed));
        for (j = 0; j < 8; j++) begin
            cw = encode_nibble(nib) ^ (8'b1 << j);
            drive_line_frame(cw, frame_parity(cw));
            wait_result(res);
            check_result(res, nib, 1'b1, 1'b0, 1'b0, 1'b1);
        end

        // Two flipped bits
        for (j = 0; j < 6; j++) begin
            nib = 4'($random(seed));
            cw  = encode_nibble(nib) ^ pair_masks[j];
            drive_line_frame(cw, frame_parity(cw));
            wait_result(res);
            check_result(res, nib, 1'b0, 1'b1, 1'b0, 1'b0);
        end

        // Clean codeword with inverted frame parity
        nib = 4'($random(seed));
        cw  = encode_nibble(nib);
        drive_line_frame(cw, ~frame_parity(cw));
        wait_result(res);
        check_result(res, nib, 1'b0, 1'b0, 1'b1, 1'b1);

        // Second send in the middle of a frame is dropped
        use_loopback = 1'b1;
        nib = 4'($random(seed));
        wait_tx_idle();
        host_send(nib);
        repeat (FRAME_CLKS / 2) @(posedge clk);
        #DRIVE_DELAY;
        assert (busy === 1'b1)
            else stop_on_error($sformatf("FAIL at time %0t: busy low mid frame", $time));
        host_send(~nib);
        wait_result(res);
        check_result(res, nib, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (2 * FRAME_CLKS) @(posedge clk);  // Window for a stray second frame
        #DRIVE_DELAY;
        assert (results.size() == 0 && busy === 1'b0)
            else stop_on_error($sformatf("FAIL at time %0t: dropped send was sent", $time));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
